// ==== fpga_tile.f ====
+incdir+common
common/fpga_tile_pkg.sv
src/config_loader.sv
slice/logic_slice.sv
routing/input_conn_block.sv
routing/switch_box.sv
src/logic_tile.sv
dv/clk_gen.sv
dv/logic_tile_tb.sv

// ==== Bender.yml ====
package:
  name: fpga_tile

export_include_dirs:
  - common

sources:
  - files:
      - common/fpga_tile_pkg.sv
      - src/config_loader.sv
      - slice/logic_slice.sv
      - routing/input_conn_block.sv
      - routing/switch_box.sv
      - src/logic_tile.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/logic_tile_tb.sv

// ==== dv/logic_tile_tb.sv ====
`timescale 1ns/1ps
`include "fpga_tile_config.svh"

module logic_tile_tb;

  localparam int NUM_ROWS   = 6;
  localparam int WAIT_LIMIT = 40;
  localparam int NW         = `TILE_CHAIN_WORDS;

  logic                     clk;
  logic                     rst_n;
  logic                     cen;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [`TILE_APB_AW-1:0]  paddr;
  fpga_tile_pkg::cfg_word_t pwdata;
  fpga_tile_pkg::cfg_word_t prdata;
  logic                     pready;
  logic                     pslverr;
  logic [`TILE_WS-1:0]      west_in;
  logic [`TILE_WS-1:0]      south_in;
  logic [`TILE_WS-1:0]      east_out;
  logic [`TILE_WS-1:0]      north_out;
  logic                     carry_in;
  logic                     carry_out;

  // Stimulus table with the configuration words kept in write order
  string       row_name [NUM_ROWS];
  int          row_vecs [NUM_ROWS];
  bit          row_cen_rand [NUM_ROWS];
  logic [15:0] cfg_tab [NUM_ROWS*NW];

  // Reference state holds the active configuration, the write history and the LUT register
  logic [15:0] act_cfg [NW];
  logic [15:0] wr_hist [$];
  logic [3:0]  exp_reg;
  logic [3:0]  prev_comb;
  logic        prev_cen;
  logic [31:0] lcg_state;
  int          last_wait;
  int          err_cnt;
  int          check_cnt;
  int          test_cnt;
  int          test_fail_cnt;

  clk_gen clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  logic_tile uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cen       (cen),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .west_in   (west_in),
    .south_in  (south_in),
    .east_out  (east_out),
    .north_out (north_out),
    .carry_in  (carry_in),
    .carry_out (carry_out)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [15:0] rand_word();
    logic [31:0] r;
    r = lcg_next();
    return r[31:16];
  endfunction

  // Routing sources are west 0-3, south 4-7, LUT 8-11 and registered 12-15
  function automatic logic pick_source(logic [3:0] sel, logic [3:0] w, logic [3:0] s,
                                       logic [3:0] comb, logic [3:0] r);
    case (sel[3:2])
      2'd0: return w[sel[1:0]];
      2'd1: return s[sel[1:0]];
      2'd2: return comb[sel[1:0]];
      default: return r[sel[1:0]];
    endcase
  endfunction

  // Returns {lut outputs, carry_out, north_out, east_out} for the active configuration
  function automatic logic [12:0] expect_tile(logic [3:0] w, logic [3:0] s, logic ci,
                                              logic [3:0] r);
    logic [3:0] idx;
    logic [3:0] comb;
    logic [3:0] east;
    logic [3:0] north;
    logic       c;
    c = ci;
    for (int k = 0; k < 4; k++) begin
      // Connection block selects ignore bit 3, so only tracks are reachable
      for (int j = 0; j < 4; j++) begin
        idx[j] = pick_source({1'b0, act_cfg[2+k][4*j +: 3]}, w, s, 4'h0, 4'h0);
      end
      comb[k] = act_cfg[6+k][idx];
      if (!comb[k]) begin
        c = idx[0];
      end
    end
    for (int i = 0; i < 4; i++) begin
      east[i]  = pick_source(act_cfg[0][4*i +: 4], w, s, comb, r);
      north[i] = pick_source(act_cfg[1][4*i +: 4], w, s, comb, r);
    end
    return {comb, c, north, east};
  endfunction

  task automatic check_val(string name, logic [31:0] exp_v, logic [31:0] act_v);
    check_cnt++;
    if (exp_v !== act_v) begin
      err_cnt++;
      $display("ERR %s expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic apb_xfer(logic wr, logic [7:0] addr, logic [15:0] wdata,
                          output logic [15:0] rdata, output logic err);
    int waited;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!pready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!pready) begin
      $display("pready stayed low for %0d cycles on APB access to 0x%h", WAIT_LIMIT, addr);
      $display("SOME TESTS FAILED");
      $finish;
    end else begin
      last_wait = waited;
      rdata     = prdata;
      err       = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
    end
  endtask

  task automatic apb_write(logic [7:0] addr, logic [15:0] wdata, output logic err);
    logic [15:0] unused;
    apb_xfer(1'b1, addr, wdata, unused, err);
  endtask

  task automatic apb_read(logic [7:0] addr, output logic [15:0] rdata, output logic err);
    apb_xfer(1'b0, addr, 16'h0000, rdata, err);
  endtask

  task automatic wait_reset();
    int waited;
    waited = 0;
    while (rst_n !== 1'b1 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was not released within 20 cycles");
      $display("SOME TESTS FAILED");
      $finish;
    end else begin
      @(negedge clk);
    end
  endtask

  task automatic put_row(int row, string name, int vecs, bit cen_random,
                         logic [15:0] sb0, logic [15:0] sb1);
    row_name[row]       = name;
    row_vecs[row]       = vecs;
    row_cen_rand[row]   = cen_random;
    cfg_tab[row*NW]     = sb0;
    cfg_tab[row*NW + 1] = sb1;
  endtask

  task automatic put_words(int row, int base, logic [15:0] w0, logic [15:0] w1,
                           logic [15:0] w2, logic [15:0] w3);
    cfg_tab[row*NW + base]     = w0;
    cfg_tab[row*NW + base + 1] = w1;
    cfg_tab[row*NW + base + 2] = w2;
    cfg_tab[row*NW + base + 3] = w3;
  endtask

  // Words 2-5 go to the connection block and 6-9 to the slice truth tables
  task automatic fill_table();
    put_row(0, "route_pass", 16, 1'b0, 16'h4701, 16'h2563);
    put_words(0, 2, rand_word(), rand_word(), rand_word(), rand_word());
    put_words(0, 6, rand_word(), rand_word(), rand_word(), rand_word());
    put_row(1, "lut_and", 24, 1'b1, 16'hBA98, 16'hFEDC);
    put_words(1, 2, 16'h3210, 16'h7654, 16'h5140, 16'hF9A3);
    put_words(1, 6, 16'h8000, 16'h8000, 16'h8000, 16'h8000);
    put_row(2, "lut_xor", 24, 1'b0, 16'h89AB, 16'hCDEF);
    put_words(2, 2, 16'h3210, 16'h7654, 16'h5140, 16'hF9A3);
    put_words(2, 6, 16'h6996, 16'h6996, 16'h6996, 16'h6996);
    put_row(3, "lut_random", 32, 1'b1, rand_word() | 16'h8888, rand_word());
    put_words(3, 2, rand_word(), rand_word(), rand_word(), rand_word());
    put_words(3, 6, rand_word(), rand_word(), rand_word(), rand_word());
    put_row(4, "carry_chain", 32, 1'b1, 16'hFCB8, 16'h9E40);
    put_words(4, 2, rand_word(), rand_word(), rand_word(), rand_word());
    put_words(4, 6, rand_word(), rand_word(), rand_word(), rand_word());
    // Same routing as the first row over different slice contents
    put_row(5, "route_reslice", 16, 1'b1, 16'h4701, 16'h2563);
    put_words(5, 2, rand_word(), rand_word(), rand_word(), rand_word());
    put_words(5, 6, rand_word(), rand_word(), rand_word(), rand_word());
  endtask

  task automatic run_vector(string name, bit cen_random);
    logic [31:0] rnd;
    logic [12:0] exp_v;
    logic        cen_v;
    rnd   = lcg_next();
    cen_v = cen_random ? rnd[20] : 1'b1;
    @(posedge clk);
    // The LUT register took the previous vector's value on this edge
    if (prev_cen) begin
      exp_reg = prev_comb;
    end
    west_in  <= rnd[31:28];
    south_in <= rnd[27:24];
    carry_in <= rnd[23];
    cen      <= cen_v;
    @(negedge clk);
    exp_v = expect_tile(rnd[31:28], rnd[27:24], rnd[23], exp_reg);
    check_val({name, " east"}, exp_v[3:0], east_out);
    check_val({name, " north"}, exp_v[7:4], north_out);
    check_val({name, " carry"}, exp_v[8], carry_out);
    prev_comb = exp_v[12:9];
    prev_cen  = cen_v;
  endtask

  task automatic park_cen();
    @(posedge clk);
    if (prev_cen) begin
      exp_reg = prev_comb;
    end
    cen <= 1'b0;
    prev_cen = 1'b0;
  endtask

  // Each DATA write pushes out the word written ten writes before it
  task automatic load_row(int row);
    logic [15:0] word;
    logic [15:0] rd;
    logic [15:0] exp_rd;
    logic        err;
    int          n;
    for (int w = 0; w < NW; w++) begin
      word   = cfg_tab[row*NW + w];
      n      = wr_hist.size();
      exp_rd = (n >= NW) ? wr_hist[n-NW] : 16'h0000;
      apb_write(fpga_tile_pkg::REG_DATA, word, err);
      check_val({row_name[row], " data pslverr"}, 0, err);
      // A DATA write holds pready low while its sixteen bits shift out
      check_val({row_name[row], " data wait"}, 16, last_wait);
      wr_hist.push_back(word);
      apb_read(fpga_tile_pkg::REG_DATA, rd, err);
      check_val({row_name[row], " readback"}, exp_rd, rd);
      check_val({row_name[row], " readback wait"}, 0, last_wait);
    end
  endtask

  task automatic report_test(string name, int first_err);
    test_cnt++;
    if (err_cnt != first_err) begin
      test_fail_cnt++;
      $display("test %s: %0d mismatches", name, err_cnt - first_err);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  initial begin
    logic [15:0] rd;
    logic        err;
    int          first_err;
    lcg_state     = 32'h52d3_9c69;
    err_cnt       = 0;
    check_cnt     = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    last_wait     = 0;
    exp_reg       = 4'h0;
    prev_comb     = 4'h0;
    prev_cen      = 1'b0;
    psel     <= 1'b0;
    penable  <= 1'b0;
    pwrite   <= 1'b0;
    paddr    <= '0;
    pwdata   <= '0;
    cen      <= 1'b0;
    west_in  <= '0;
    south_in <= '0;
    carry_in <= 1'b0;
    for (int w = 0; w < NW; w++) begin
      act_cfg[w] = 16'h0000;
    end
    fill_table();
    wait_reset();

    first_err = err_cnt;
    check_val("reset east", 0, east_out);
    check_val("reset north", 0, north_out);
    check_val("reset carry", 0, carry_out);
    apb_read(fpga_tile_pkg::REG_STATUS, rd, err);
    check_val("reset status", 0, rd);
    apb_read(fpga_tile_pkg::REG_DATA, rd, err);
    check_val("reset data", 0, rd);
    report_test("reset", first_err);

    first_err = err_cnt;
    apb_write(8'h0C, 16'hFFFF, err);
    check_val("bad_addr write pslverr", 1, err);
    apb_read(8'h10, rd, err);
    check_val("bad_addr read pslverr", 1, err);
    apb_read(fpga_tile_pkg::REG_STATUS, rd, err);
    check_val("bad_addr status", 0, rd);
    report_test("bad_addr", first_err);

    for (int row = 0; row < NUM_ROWS; row++) begin
      first_err = err_cnt;
      load_row(row);
      // A CTRL write with bit0 clear leaves the old configuration active
      apb_write(fpga_tile_pkg::REG_CTRL, 16'h0000, err);
      for (int v = 0; v < 4; v++) begin
        run_vector({row_name[row], " pre_set"}, row_cen_rand[row]);
      end
      park_cen();
      apb_write(fpga_tile_pkg::REG_CTRL, 16'h0001, err);
      check_val({row_name[row], " ctrl wait"}, 0, last_wait);
      for (int w = 0; w < NW; w++) begin
        act_cfg[w] = cfg_tab[row*NW + w];
      end
      apb_read(fpga_tile_pkg::REG_STATUS, rd, err);
      check_val({row_name[row], " status"}, 16'h0001, rd);
      for (int v = 0; v < row_vecs[row]; v++) begin
        run_vector(row_name[row], row_cen_rand[row]);
      end
      park_cen();
      report_test(row_name[row], first_err);
    end

    $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
             test_cnt, test_fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset is held low for the first ten rising edges
  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== src/logic_tile.sv ====
`timescale 1ns/1ps
`include "fpga_tile_config.svh"

module logic_tile (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cen,

  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`TILE_APB_AW-1:0]  paddr,
  input  fpga_tile_pkg::cfg_word_t pwdata,
  output fpga_tile_pkg::cfg_word_t prdata,
  output logic                     pready,
  output logic                     pslverr,

  input  logic [`TILE_WS-1:0]      west_in,
  input  logic [`TILE_WS-1:0]      south_in,
  output logic [`TILE_WS-1:0]      east_out,
  output logic [`TILE_WS-1:0]      north_out,

  input  logic                     carry_in,
  output logic                     carry_out
);

  // Chain order is loader, slice, connection block, switch box, back to loader
  logic cfg_shift_en;
  logic cfg_bit;
  logic cfg_set;
  logic slice_so;
  logic icb_so;
  logic sb_so;

  logic [`TILE_NUM_LUTS*`TILE_LUT_K-1:0] lut_in;
  logic [`TILE_NUM_LUTS-1:0]             lut_out;
  logic [`TILE_NUM_LUTS-1:0]             lut_out_reg;

  config_loader loader (
    .clk          (clk),
    .rst_n        (rst_n),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .cfg_tail     (sb_so),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .cfg_shift_en (cfg_shift_en),
    .cfg_bit      (cfg_bit),
    .cfg_set      (cfg_set)
  );

  logic_slice slice (
    .clk          (clk),
    .rst_n        (rst_n),
    .cen          (cen),
    .cfg_shift_en (cfg_shift_en),
    .cfg_bit      (cfg_bit),
    .cfg_set      (cfg_set),
    .lut_in       (lut_in),
    .carry_in     (carry_in),
    .cfg_out      (slice_so),
    .lut_out      (lut_out),
    .lut_out_reg  (lut_out_reg),
    .carry_out    (carry_out)
  );

  input_conn_block icb (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_shift_en (cfg_shift_en),
    .cfg_bit      (slice_so),
    .cfg_set      (cfg_set),
    .west_in      (west_in),
    .south_in     (south_in),
    .cfg_out      (icb_so),
    .lut_in       (lut_in)
  );

  switch_box sb (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_shift_en (cfg_shift_en),
    .cfg_bit      (icb_so),
    .cfg_set      (cfg_set),
    .west_in      (west_in),
    .south_in     (south_in),
    .lut_out      (lut_out),
    .lut_out_reg  (lut_out_reg),
    .cfg_out      (sb_so),
    .east_out     (east_out),
    .north_out    (north_out)
  );

endmodule

// ==== routing/switch_box.sv ====
`timescale 1ns/1ps
`include "fpga_tile_config.svh"

module switch_box (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cfg_shift_en,
  input  logic                      cfg_bit,
  input  logic                      cfg_set,
  input  logic [`TILE_WS-1:0]       west_in,
  input  logic [`TILE_WS-1:0]       south_in,
  input  logic [`TILE_NUM_LUTS-1:0] lut_out,
  input  logic [`TILE_NUM_LUTS-1:0] lut_out_reg,
  output logic                      cfg_out,
  output logic [`TILE_WS-1:0]       east_out,
  output logic [`TILE_WS-1:0]       north_out
);

  localparam int SR_W = `TILE_SB_WORDS * `TILE_CFG_W;

  logic [SR_W-1:0]                                  shift_q;
  fpga_tile_pkg::cfg_word_t                         sel_q [`TILE_SB_WORDS];
  logic [2*`TILE_WS+2*`TILE_NUM_LUTS-1:0]           sources;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shift_q <= '0;
    end else if (cfg_shift_en) begin
      shift_q <= {shift_q[SR_W-2:0], cfg_bit};
    end
  end

  // This is the end of the chain, the bit returns to the loader
  assign cfg_out = shift_q[SR_W-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < `TILE_SB_WORDS; k++) begin
        sel_q[k] <= '0;
      end
    end else if (cfg_set) begin
      for (int k = 0; k < `TILE_SB_WORDS; k++) begin
        sel_q[k] <= shift_q[(`TILE_SB_WORDS-k)*`TILE_CFG_W-1 -: `TILE_CFG_W];
      end
    end
  end

  // Source numbering: west 0-3, south 4-7, LUT outputs 8-11, registered 12-15
  assign sources = {lut_out_reg, lut_out, south_in, west_in};

  // Word 0 steers the east side and word 1 the north side
  always_comb begin
    fpga_tile_pkg::src_sel_t east_sel;
    fpga_tile_pkg::src_sel_t north_sel;
    for (int i = 0; i < `TILE_WS; i++) begin
      east_sel     = sel_q[0][i*`TILE_SEL_W +: `TILE_SEL_W];
      north_sel    = sel_q[1][i*`TILE_SEL_W +: `TILE_SEL_W];
      east_out[i]  = sources[east_sel];
      north_out[i] = sources[north_sel];
    end
  end

endmodule

// ==== routing/input_conn_block.sv ====
`timescale 1ns/1ps
`include "fpga_tile_config.svh"

module input_conn_block (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  cfg_shift_en,
  input  logic                                  cfg_bit,
  input  logic                                  cfg_set,
  input  logic [`TILE_WS-1:0]                   west_in,
  input  logic [`TILE_WS-1:0]                   south_in,
  output logic                                  cfg_out,
  output logic [`TILE_NUM_LUTS*`TILE_LUT_K-1:0] lut_in
);

  localparam int SR_W      = `TILE_ICB_WORDS * `TILE_CFG_W;
  localparam int TRK_IDX_W = $clog2(2 * `TILE_WS);

  logic [SR_W-1:0]          shift_q;
  fpga_tile_pkg::cfg_word_t sel_q [`TILE_ICB_WORDS];
  logic [2*`TILE_WS-1:0]    tracks;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shift_q <= '0;
    end else if (cfg_shift_en) begin
      shift_q <= {shift_q[SR_W-2:0], cfg_bit};
    end
  end

  assign cfg_out = shift_q[SR_W-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < `TILE_ICB_WORDS; k++) begin
        sel_q[k] <= '0;
      end
    end else if (cfg_set) begin
      for (int k = 0; k < `TILE_ICB_WORDS; k++) begin
        sel_q[k] <= shift_q[(`TILE_ICB_WORDS-k)*`TILE_CFG_W-1 -: `TILE_CFG_W];
      end
    end
  end

  // West tracks are sources 0 to 3 and south tracks 4 to 7
  assign tracks = {south_in, west_in};

  // Word k feeds LUT k, nibble j picks that LUT's input j.
  // The top select bit has no meaning here
  always_comb begin
    fpga_tile_pkg::src_sel_t sel;
    for (int k = 0; k < `TILE_NUM_LUTS; k++) begin
      for (int j = 0; j < `TILE_LUT_K; j++) begin
        sel = sel_q[k][j*`TILE_SEL_W +: `TILE_SEL_W];
        lut_in[k*`TILE_LUT_K + j] = tracks[sel[TRK_IDX_W-1:0]];
      end
    end
  end

endmodule

// ==== slice/logic_slice.sv ====
`timescale 1ns/1ps
`include "fpga_tile_config.svh"

module logic_slice (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  cen,
  input  logic                                  cfg_shift_en,
  input  logic                                  cfg_bit,
  input  logic                                  cfg_set,
  input  logic [`TILE_NUM_LUTS*`TILE_LUT_K-1:0] lut_in,
  input  logic                                  carry_in,
  output logic                                  cfg_out,
  output logic [`TILE_NUM_LUTS-1:0]             lut_out,
  output logic [`TILE_NUM_LUTS-1:0]             lut_out_reg,
  output logic                                  carry_out
);

  localparam int SR_W = `TILE_SLICE_WORDS * `TILE_CFG_W;

  logic [SR_W-1:0]          shift_q;
  fpga_tile_pkg::cfg_word_t truth_q [`TILE_SLICE_WORDS];
  logic [`TILE_NUM_LUTS:0]  carry;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shift_q <= '0;
    end else if (cfg_shift_en) begin
      shift_q <= {shift_q[SR_W-2:0], cfg_bit};
    end
  end

  assign cfg_out = shift_q[SR_W-1];

  // Word 0 sits at the top of the shift register since it went in first
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < `TILE_SLICE_WORDS; k++) begin
        truth_q[k] <= '0;
      end
    end else if (cfg_set) begin
      for (int k = 0; k < `TILE_SLICE_WORDS; k++) begin
        truth_q[k] <= shift_q[(`TILE_SLICE_WORDS-k)*`TILE_CFG_W-1 -: `TILE_CFG_W];
      end
    end
  end

  // Each LUT indexes its truth table with its four inputs, in3 as MSB.
  // The carry ripples through a LUT when its output is 1, otherwise input 0
  // generates the new carry
  always_comb begin
    carry[0] = carry_in;
    for (int k = 0; k < `TILE_NUM_LUTS; k++) begin
      lut_out[k]   = truth_q[k][lut_in[k*`TILE_LUT_K +: `TILE_LUT_K]];
      carry[k+1] = lut_out[k] ? carry[k] : lut_in[k*`TILE_LUT_K];
    end
  end

  assign carry_out = carry[`TILE_NUM_LUTS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lut_out_reg <= '0;
    end else if (cen) begin
      lut_out_reg <= lut_out;
    end
  end

endmodule

// ==== src/config_loader.sv ====
`timescale 1ns/1ps
`include "fpga_tile_config.svh"

module config_loader (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`TILE_APB_AW-1:0]  paddr,
  input  fpga_tile_pkg::cfg_word_t pwdata,
  input  logic                     cfg_tail,
  output fpga_tile_pkg::cfg_word_t prdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic                     cfg_shift_en,
  output logic                     cfg_bit,
  output logic                     cfg_set
);

  localparam int CNT_W = $clog2(`TILE_CFG_W);

  logic                     setup_phase;
  logic                     access_phase;
  logic                     sel_data;
  logic                     sel_ctrl;
  logic                     sel_status;
  logic                     sel_bad;
  logic                     data_wr;
  logic                     wr_done;
  logic                     configured;
  logic [CNT_W-1:0]         bit_cnt;
  fpga_tile_pkg::cfg_word_t word_q;
  fpga_tile_pkg::cfg_word_t rdback_q;

  assign setup_phase  = psel & ~penable;
  assign access_phase = psel & penable;

  assign sel_data   = (paddr == fpga_tile_pkg::REG_DATA);
  assign sel_ctrl   = (paddr == fpga_tile_pkg::REG_CTRL);
  assign sel_status = (paddr == fpga_tile_pkg::REG_STATUS);
  assign sel_bad    = ~(sel_data | sel_ctrl | sel_status);

  assign data_wr = sel_data & pwrite;

  // Only a DATA write waits, everything else completes in its first access cycle
  assign pready  = access_phase & (~data_wr | wr_done);
  assign pslverr = access_phase & sel_bad;

  // The chain is fed MSB first
  assign cfg_bit = word_q[`TILE_CFG_W-1];

  always_comb begin
    prdata = '0;
    if (sel_data) begin
      prdata = rdback_q;
    end else if (sel_status) begin
      prdata[0] = configured;
    end
  end

  // The word is captured during the setup phase so that shifting can start
  // on the first access cycle
  always_ff @(posedge clk) begin
    if (setup_phase && data_wr) begin
      word_q <= pwdata;
    end else if (cfg_shift_en) begin
      word_q <= {word_q[`TILE_CFG_W-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_shift_en <= 1'b0;
      bit_cnt      <= '0;
      wr_done      <= 1'b0;
      cfg_set      <= 1'b0;
      configured   <= 1'b0;
      rdback_q     <= '0;
    end else begin
      cfg_set <= 1'b0;

      if (access_phase && pready) begin
        wr_done <= 1'b0;
      end

      if (setup_phase && data_wr) begin
        cfg_shift_en <= 1'b1;
        bit_cnt      <= '0;
      end else if (cfg_shift_en) begin
        bit_cnt  <= bit_cnt + 1'b1;
        // Whatever leaves the switch box tail is the word pushed out of the chain
        rdback_q <= {rdback_q[`TILE_CFG_W-2:0], cfg_tail};
        if (bit_cnt == CNT_W'(`TILE_CFG_W - 1)) begin
          cfg_shift_en <= 1'b0;
          wr_done      <= 1'b1;
        end
      end

      // Set pulse appears on the cycle after the CTRL access
      if (access_phase && pwrite && sel_ctrl && pwdata[0]) begin
        cfg_set <= 1'b1;
      end

      if (cfg_set) begin
        configured <= 1'b1;
      end
    end
  end

endmodule

// ==== common/fpga_tile_pkg.sv ====
`include "fpga_tile_config.svh"

package fpga_tile_pkg;

  // A single configuration word as it travels over APB and down the chain
  typedef logic [`TILE_CFG_W-1:0] cfg_word_t;

  // Routing select field, one per LUT input or per outgoing track
  typedef logic [`TILE_SEL_W-1:0] src_sel_t;

  // Loader register map
  typedef enum logic [`TILE_APB_AW-1:0] {
    REG_DATA   = 8'h00,
    REG_CTRL   = 8'h04,
    REG_STATUS = 8'h08
  } apb_reg_e;

endpackage

// ==== common/fpga_tile_config.svh ====
`ifndef FPGA_TILE_CONFIG_SVH
`define FPGA_TILE_CONFIG_SVH

// One configuration word, also the APB data width
`define TILE_CFG_W 16

// Logic slice geometry
`define TILE_NUM_LUTS 4
`define TILE_LUT_K 4

// Single-length tracks per side
`define TILE_WS 4

// Width of one routing select field inside a configuration word
`define TILE_SEL_W 4

// Configuration words held by each block of the chain
`define TILE_SLICE_WORDS 4
`define TILE_ICB_WORDS 4
`define TILE_SB_WORDS 2
`define TILE_CHAIN_WORDS 10

`define TILE_APB_AW 8

`endif
